// ==== rtl/conv_pad_pkg.sv ====
// ********************
// sizes, side-band layout and register map of the padding stage
// module parameters must not exceed the maxima sized here
// ********************
`default_nettype none

package conv_pad_pkg;

    localparam int KW_MAX   = 7;   // largest odd kernel width
    localparam int SW_MAX   = 4;   // largest stride
    localparam int MEMBERS  = 12;  // datapaths with a mask bit

    localparam int BITS_KW2  = $clog2(KW_MAX / 2 + 1);  // 7 -> kw2 up to 3
    localparam int BITS_SW   = $clog2(SW_MAX);          // holds stride - 1
    localparam int BITS_COLS = 10;                      // up to 1023 columns
    localparam int BITS_CINS = 10;                      // up to 1023 channels
    localparam int BITS_CLR  = $clog2(KW_MAX + 1);      // left | right code

    // side-band word of a beat
    localparam int I_IS_CONFIG    = 0;
    localparam int I_IS_CIN_LAST  = 1;
    localparam int I_IS_COLS_1_K2 = 2;
    localparam int I_IS_COL_VALID = 3;
    localparam int I_KW2          = 4;
    localparam int I_SW_1         = I_KW2 + BITS_KW2;
    localparam int TUSER_WIDTH    = I_SW_1 + BITS_SW;

    typedef enum logic [4:0] {
        ADDR_KW2    = 5'h00,
        ADDR_SW     = 5'h04,
        ADDR_COLS   = 5'h08,
        ADDR_CINS   = 5'h0C,
        ADDR_CTRL   = 5'h10,  // bit 0 starts a frame
        ADDR_STATUS = 5'h14   // bit 0 busy, bit 1 done
    } cfg_addr_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CONFIG,  // single config beat
        S_RUN,     // cols * cins data beats
        S_DONE
    } frame_state_e;

endpackage

`default_nettype wire

// ==== rtl/axil_conv_cfg.sv ====
// ********************
// AXI4-Lite config slave, host presents aw and w together
// config writes while busy are dropped with OKAY
// ********************
`default_nettype none

module axil_conv_cfg import conv_pad_pkg::*; (
    input  wire logic                 aclk,
    input  wire logic                 rst_n,
    input  wire logic [4:0]           aw_addr,
    input  wire logic                 aw_valid,
    output logic                      aw_ready,
    input  wire logic [31:0]          w_data,
    input  wire logic                 w_valid,
    output logic                      w_ready,
    output logic                      b_valid,
    output logic [1:0]                b_resp,
    input  wire logic                 b_ready,
    input  wire logic [4:0]           ar_addr,
    input  wire logic                 ar_valid,
    output logic                      ar_ready,
    output logic                      r_valid,
    output logic [31:0]               r_data,
    output logic [1:0]                r_resp,
    input  wire logic                 r_ready,
    input  wire logic                 busy,
    input  wire logic                 done_pulse,
    output logic [BITS_KW2-1:0]       kw2,
    output logic [BITS_SW-1:0]        sw_1,
    output logic [BITS_COLS-1:0]      cols,
    output logic [BITS_CINS-1:0]      cins,
    output logic                      start_pulse
);

    logic wr_en;      // aw and w taken this cycle
    logic rd_en;
    logic done_flag;  // sticky until next start

    assign aw_ready = !b_valid;  // one write in flight
    assign w_ready  = !b_valid;
    assign ar_ready = !r_valid;
    assign b_resp   = 2'b00;     // always OKAY
    assign r_resp   = 2'b00;
    assign wr_en    = aw_valid && w_valid && aw_ready;
    assign rd_en    = ar_valid && ar_ready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            kw2         <= '0;
            sw_1        <= '0;
            cols        <= '0;
            cins        <= '0;
            b_valid     <= 1'b0;
            start_pulse <= 1'b0;
            done_flag   <= 1'b0;
        end else begin
            start_pulse <= wr_en && (aw_addr == ADDR_CTRL) && w_data[0] && !busy;
            if (wr_en) begin
                b_valid <= 1'b1;  // response one cycle after accept
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (wr_en && !busy) begin
                case (cfg_addr_e'(aw_addr))
                    ADDR_KW2:  kw2  <= w_data[BITS_KW2-1:0];
                    ADDR_SW:   sw_1 <= w_data[BITS_SW-1:0];
                    ADDR_COLS: cols <= w_data[BITS_COLS-1:0];
                    ADDR_CINS: cins <= w_data[BITS_CINS-1:0];
                    default: ;    // ctrl handled above, status read only
                endcase
            end
            if (start_pulse) begin
                done_flag <= 1'b0;
            end else if (done_pulse) begin
                done_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (rd_en) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_en) begin
            case (cfg_addr_e'(ar_addr))
                ADDR_KW2:    r_data <= 32'(kw2);
                ADDR_SW:     r_data <= 32'(sw_1);
                ADDR_COLS:   r_data <= 32'(cols);
                ADDR_CINS:   r_data <= 32'(cins);
                ADDR_STATUS: r_data <= {30'd0, done_flag, busy};
                default:     r_data <= '0;  // ctrl and holes read zero
            endcase
        end
    end

    // a response must follow an accepted write
    a_bvalid_after_write: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(b_valid) |-> $past(wr_en));

endmodule

`default_nettype wire

// ==== rtl/conv_frame_fsm.sv ====
// ********************
// frame sequencer, idle -> config beat -> run -> done
// start is ignored until back in idle
// ********************
`default_nettype none

module conv_frame_fsm import conv_pad_pkg::*; (
    input  wire logic  aclk,
    input  wire logic  rst_n,
    input  wire logic  start_pulse,
    input  wire logic  out_ready,
    input  wire logic  frame_last,
    output frame_state_e state,
    output logic       beat_valid_int,
    output logic       cfg_beat,
    output logic       busy,
    output logic       done_pulse
);

    frame_state_e state_nxt;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (start_pulse) state_nxt = S_CONFIG;
            S_CONFIG: if (cfg_beat && out_ready) state_nxt = S_RUN;  // config beat taken
            S_RUN:    if (frame_last && out_ready) state_nxt = S_DONE;
            S_DONE:   state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    assign cfg_beat       = (state == S_CONFIG);
    assign beat_valid_int = cfg_beat || (state == S_RUN);
    assign busy           = (state != S_IDLE);
    assign done_pulse     = (state == S_DONE);  // one cycle, done leaves at once

    // the status done bit counts on a single pulse per frame
    a_done_one_cycle: assert property (@(posedge aclk) disable iff (!rst_n)
        done_pulse |=> !done_pulse);

endmodule

`default_nettype wire

// ==== rtl/col_scan_counter.sv ====
// ********************
// channel-inside-column scan of one frame
// kw2 and sw_1 saturate at the supported maxima
// ********************
`default_nettype none

module col_scan_counter import conv_pad_pkg::*; #(
    parameter int KW_MAX = conv_pad_pkg::KW_MAX,
    parameter int SW_MAX = conv_pad_pkg::SW_MAX
) (
    input  wire logic                  aclk,
    input  wire logic                  rst_n,
    input  wire frame_state_e          state,
    input  wire logic                  beat_valid_int,
    input  wire logic                  out_ready,
    input  wire logic [BITS_KW2-1:0]   kw2,
    input  wire logic [BITS_SW-1:0]    sw_1,
    input  wire logic [BITS_COLS-1:0]  cols,
    input  wire logic [BITS_CINS-1:0]  cins,
    output logic [TUSER_WIDTH-1:0]     user_word,
    output logic                       frame_last
);

    localparam logic [BITS_KW2-1:0] KW2_LIM = BITS_KW2'(KW_MAX / 2);
    localparam logic [BITS_SW-1:0]  SW_LIM  = BITS_SW'(SW_MAX - 1);

    logic [BITS_COLS-1:0] col_cnt;
    logic [BITS_CINS-1:0] cin_cnt;
    logic [BITS_KW2-1:0]  kw2_c;
    logic [BITS_SW-1:0]   sw_c;
    logic run, accept, cin_last, col_last, cols_1_k2;

    assign run       = (state == S_RUN);
    assign accept    = beat_valid_int && out_ready;
    assign kw2_c     = (kw2 > KW2_LIM) ? KW2_LIM : kw2;
    assign sw_c      = (sw_1 > SW_LIM) ? SW_LIM : sw_1;
    assign cin_last  = run && (cin_cnt == cins - 1'b1);
    assign col_last  = (col_cnt == cols - 1'b1);
    assign cols_1_k2 = run && (kw2_c != '0) && (col_cnt == cols - 1'b1 - BITS_COLS'(kw2_c));
    assign frame_last = cin_last && col_last;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            cin_cnt <= '0;
        end else if (accept) begin
            if (state == S_CONFIG) begin
                col_cnt <= '0;  // fresh frame
                cin_cnt <= '0;
            end else if (cin_last) begin
                cin_cnt <= '0;
                col_cnt <= col_last ? '0 : col_cnt + 1'b1;
            end else begin
                cin_cnt <= cin_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        user_word                       = '0;
        user_word[I_IS_CONFIG]          = (state == S_CONFIG);
        user_word[I_IS_CIN_LAST]        = cin_last;
        user_word[I_IS_COLS_1_K2]       = cols_1_k2;
        user_word[I_IS_COL_VALID]       = run;  // every run beat carries a column
        user_word[I_KW2 +: BITS_KW2]    = kw2_c;
        user_word[I_SW_1 +: BITS_SW]    = sw_c;
    end

    // counts stay inside the configured frame
    a_counts_in_range: assert property (@(posedge aclk) disable iff (!rst_n)
        (state == S_RUN) |-> (col_cnt < cols) && (cin_cnt < cins));

endmodule

`default_nettype wire

// ==== rtl/pad_filter.sv ====
// ********************
// horizontal padding masks, one register stage
// lookups built for every kw2 / sw_1 pair, so kernels may change per frame
// kw2 and sw_1 must already be within the maxima
// ********************
`default_nettype none

module pad_filter import conv_pad_pkg::*; #(
    parameter int KW_MAX  = conv_pad_pkg::KW_MAX,
    parameter int SW_MAX  = conv_pad_pkg::SW_MAX,
    parameter int MEMBERS = conv_pad_pkg::MEMBERS
) (
    input  wire logic                   aclk,
    input  wire logic                   rst_n,
    input  wire logic [TUSER_WIDTH-1:0] user_word,
    input  wire logic                   beat_valid_int,
    input  wire logic                   out_ready,
    output logic                        beat_valid,
    output logic [MEMBERS-1:0]          keep_mask,
    output logic                        valid_mask,
    output logic [BITS_CLR-1:0]         clr [MEMBERS]
);

    localparam int KW2_MAX = KW_MAX / 2;  // 7 -> 3

    logic [BITS_KW2-1:0] kw2;
    logic [BITS_SW-1:0]  sw_1;
    logic is_config, cin_last, cols_1_k2, col_valid;
    logic accept, shift_en;

    assign kw2       = user_word[I_KW2 +: BITS_KW2];
    assign sw_1      = user_word[I_SW_1 +: BITS_SW];
    assign is_config = user_word[I_IS_CONFIG];
    assign cin_last  = user_word[I_IS_CIN_LAST];
    assign cols_1_k2 = user_word[I_IS_COLS_1_K2];
    assign col_valid = user_word[I_IS_COL_VALID];
    assign accept    = beat_valid_int && out_ready;
    assign shift_en  = accept && (cin_last || is_config);  // once per column

    // col_start[i] marks start column i-1, col_end[i] marks column (cols-1-kw2)+i
    logic [KW2_MAX:1] col_start;
    logic [KW2_MAX:1] col_end_r;
    logic [KW2_MAX:0] col_end;

    assign col_end = {col_end_r, 1'b0};  // bit 0 keeps kw2 = 0 out of the last column

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            col_start <= '0;
            col_end_r <= '0;
        end else if (shift_en) begin
            if (is_config) begin
                col_start <= KW2_MAX'(kw2 != '0);  // column 0 is a start column
                col_end_r <= '0;                   // no leftovers from last frame
            end else begin
                col_start <= col_start << 1;
                col_end_r <= (col_end_r << 1) | KW2_MAX'(cols_1_k2);
            end
        end
    end

    // constant lookups [kw2][sw_1] per member
    logic [MEMBERS-1:0] full_lut [KW2_MAX:0][SW_MAX];  // full datapaths
    logic [MEMBERS-1:0] part_lut [KW2_MAX:0][SW_MAX];  // partial padding, last column
    logic [MEMBERS-1:0] rmem_lut [KW2_MAX:0];          // members taking a right code

    for (genvar r = 0; r <= KW2_MAX; r++) begin : g_kw
        localparam int K = 2 * r + 1;
        for (genvar m = 0; m < MEMBERS; m++) begin : g_rm
            assign rmem_lut[r][m] = (r != 0) && ((m % K) == K - 2);  // one before last
        end
        for (genvar s1 = 0; s1 < SW_MAX; s1++) begin : g_sw
            localparam int S = s1 + 1;
            localparam int J = K + S - 1;
            for (genvar m = 0; m < MEMBERS; m++) begin : g_m
                assign full_lut[r][s1][m] = (m % J) >= K - 1;
                assign part_lut[r][s1][m] = ((m % J) >= K - 1 - S) && (m < (MEMBERS / J) * J);
            end
        end
    end

    logic                not_start;
    logic                last_col;
    logic [BITS_CLR-1:0] left_code, right_code;
    logic [MEMBERS-1:0]  keep_d;
    logic                valid_d;
    logic [BITS_CLR-1:0] clr_d [MEMBERS];

    assign last_col = col_end[kw2];

    always_comb begin
        not_start  = 1'b1;
        left_code  = '0;
        right_code = '0;
        for (int i = 1; i <= KW2_MAX; i++) begin
            if (col_start[i] && (i <= kw2)) begin
                not_start = 1'b0;
                left_code = BITS_CLR'(2 * (kw2 - i) + 1);  // 2*(kw2-c)-1 with c = i-1
            end
            if (col_end[i] && (i <= kw2)) begin
                right_code = BITS_CLR'(2 * i);
            end
        end
    end

    always_comb begin
        if (is_config || (kw2 == '0)) begin
            keep_d  = '1;  // nothing to pad
            valid_d = 1'b1;
        end else if (!not_start) begin
            keep_d  = '0;  // start columns blocked
            valid_d = 1'b0;
        end else begin
            keep_d  = full_lut[kw2][sw_1] | (last_col ? part_lut[kw2][sw_1] : '0);
            valid_d = col_valid;
        end
        for (int m = 0; m < MEMBERS; m++) begin
            if (is_config || (kw2 == '0)) begin
                clr_d[m] = '0;  // center
            end else begin
                clr_d[m] = left_code | (rmem_lut[kw2][m] ? right_code : '0);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            beat_valid <= 1'b0;
        end else if (out_ready) begin
            beat_valid <= beat_valid_int;  // holds under back-pressure
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            keep_mask  <= keep_d;
            valid_mask <= valid_d;
            clr        <= clr_d;
        end
    end

    // valid output beats never carry an odd left code
    a_no_valid_in_start: assert property (@(posedge aclk) disable iff (!rst_n)
        (beat_valid && valid_mask) |-> !clr[0][0]);

endmodule

`default_nettype wire

// ==== rtl/conv_pad_top.sv ====
// ********************
// horizontal zero padding stage, config over AXI4-Lite
// beat stream uses beat_valid / out_ready
// ********************
`default_nettype none

module conv_pad_top import conv_pad_pkg::*; #(
    parameter int KW_MAX  = conv_pad_pkg::KW_MAX,
    parameter int SW_MAX  = conv_pad_pkg::SW_MAX,
    parameter int MEMBERS = conv_pad_pkg::MEMBERS
) (
    input  wire logic          aclk,
    input  wire logic          rst_n,
    input  wire logic          out_ready,
    input  wire logic [4:0]    aw_addr,
    input  wire logic          aw_valid,
    output logic               aw_ready,
    input  wire logic [31:0]   w_data,
    input  wire logic          w_valid,
    output logic               w_ready,
    output logic               b_valid,
    output logic [1:0]         b_resp,
    input  wire logic          b_ready,
    input  wire logic [4:0]    ar_addr,
    input  wire logic          ar_valid,
    output logic               ar_ready,
    output logic               r_valid,
    output logic [31:0]        r_data,
    output logic [1:0]         r_resp,
    input  wire logic          r_ready,
    output logic               beat_valid,
    output logic [MEMBERS-1:0] keep_mask,
    output logic               valid_mask,
    output logic [BITS_CLR-1:0] clr [MEMBERS]
);

    logic [BITS_KW2-1:0]    kw2;
    logic [BITS_SW-1:0]     sw_1;
    logic [BITS_COLS-1:0]   cols;
    logic [BITS_CINS-1:0]   cins;
    logic                   start_pulse, busy, done_pulse;
    logic                   beat_valid_int, frame_last;
    logic [TUSER_WIDTH-1:0] user_word;
    frame_state_e           state;

    axil_conv_cfg cfg_i (
        .aclk, .rst_n,
        .aw_addr, .aw_valid, .aw_ready, .w_data, .w_valid, .w_ready,
        .b_valid, .b_resp, .b_ready,
        .ar_addr, .ar_valid, .ar_ready, .r_valid, .r_data, .r_resp, .r_ready,
        .busy, .done_pulse, .kw2, .sw_1, .cols, .cins, .start_pulse
    );

    conv_frame_fsm fsm_i (
        .aclk, .rst_n, .start_pulse, .out_ready, .frame_last,
        .state, .beat_valid_int,
        .cfg_beat   (),  // config flag reaches the filter inside user_word
        .busy, .done_pulse
    );

    col_scan_counter #(.KW_MAX(KW_MAX), .SW_MAX(SW_MAX)) scan_i (
        .aclk, .rst_n, .state, .beat_valid_int, .out_ready,
        .kw2, .sw_1, .cols, .cins, .user_word, .frame_last
    );

    pad_filter #(.KW_MAX(KW_MAX), .SW_MAX(SW_MAX), .MEMBERS(MEMBERS)) pad_i (
        .aclk, .rst_n, .user_word, .beat_valid_int, .out_ready,
        .beat_valid, .keep_mask, .valid_mask, .clr
    );

endmodule

`default_nettype wire

// ==== verif/pad_model.svh ====
// ********************
// expected outputs of the padding stage for one beat
// needs MEMBERS and BITS_CLR in scope, kw2 > 0 implies cols > kw2
// ********************
`ifndef PAD_MODEL_SVH
`define PAD_MODEL_SVH

typedef struct packed {
    logic [MEMBERS-1:0]          keep;
    logic                        valid;
    logic [MEMBERS*BITS_CLR-1:0] clr;    // member m sits at m*BITS_CLR
    int                          frame;
    int                          col;    // -1 on the config beat
} beat_t;

function automatic int frame_beats(input int cols, input int cins);
    return 1 + cols * cins;  // config beat plus one beat per channel and column
endfunction

// every channel beat of column c sees the same column state
function automatic beat_t expect_beat(input int kw2, input int sw_1, input int cols,
                                      input int c);
    beat_t b;
    int    k, s, j, left, right, code;
    k       = 2 * kw2 + 1;
    s       = sw_1 + 1;
    j       = k + s - 1;  // member period of one output pixel
    b.keep  = '1;
    b.valid = 1'b1;
    b.clr   = '0;
    b.frame = 0;
    b.col   = c;
    if (c < 0 || kw2 == 0) begin
        return b;  // config beat or 1-wide kernel
    end
    left    = (c < kw2) ? 2 * (kw2 - c) - 1 : 0;                        // start columns
    right   = (c > cols - 1 - kw2) ? 2 * (c - (cols - 1 - kw2)) : 0;   // last kw2 columns
    b.valid = (c >= kw2);
    for (int m = 0; m < MEMBERS; m++) begin
        if (c < kw2) begin
            b.keep[m] = 1'b0;  // blocked start column
        end else begin
            b.keep[m] = (m % j) >= k - 1;
            if (c == cols - 1 && (m % j) >= k - 1 - s && m < (MEMBERS / j) * j) begin
                b.keep[m] = 1'b1;  // partial outputs flushed in the last column
            end
        end
        code = left | (((m % k) == k - 2) ? right : 0);
        b.clr[m*BITS_CLR +: BITS_CLR] = BITS_CLR'(code);
    end
    return b;
endfunction

`endif

// ==== verif/tb_conv_pad.sv ====
// ********************
// random frames through conv_pad_top at default parameters
// out_ready low on about 30% of cycles, beats checked in order
// ********************
`default_nettype none

module tb_conv_pad import conv_pad_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES = 6;

    logic                aclk, rst_n, out_ready;
    logic [4:0]          aw_addr, ar_addr;
    logic                aw_valid, w_valid, b_ready, ar_valid, r_ready;
    logic [31:0]         w_data, r_data;
    logic                aw_ready, w_ready, b_valid, ar_ready, r_valid;
    logic [1:0]          b_resp, r_resp;
    logic                beat_valid, valid_mask;
    logic [MEMBERS-1:0]  keep_mask;
    logic [BITS_CLR-1:0] clr [MEMBERS];

    int          mismatch_cnt = 0;
    int          other_cnt    = 0;
    int          beats_seen   = 0;
    int          total_beats  = 0;
    logic [31:0] cfg_rng      = 32'd57;   // frame settings
    logic [31:0] rdy_rng      = ~32'd57;  // back-pressure, own stream
    int          f_kw2 [NUM_FRAMES];
    int          f_sw [NUM_FRAMES];
    int          f_cols [NUM_FRAMES];
    int          f_cins [NUM_FRAMES];

    `include "pad_model.svh"

    beat_t exp_q [$];  // beats still to come out, in order

    conv_pad_top dut_i (
        .aclk, .rst_n, .out_ready,
        .aw_addr, .aw_valid, .aw_ready, .w_data, .w_valid, .w_ready,
        .b_valid, .b_resp, .b_ready,
        .ar_addr, .ar_valid, .ar_ready, .r_valid, .r_data, .r_resp, .r_ready,
        .beat_valid, .keep_mask, .valid_mask, .clr
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // called just after a falling edge, returns just after one
    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data);
        aw_addr  = addr;
        w_data   = data;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        while (!(aw_ready && w_ready)) @(negedge aclk);
        @(negedge aclk);  // taken on the rising edge in between
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        while (!b_valid) @(negedge aclk);
        assert (b_resp == 2'b00) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: b_resp %b on write to %h", $time, b_resp, addr);
        end
        @(negedge aclk);  // b_ready is held high
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data);
        ar_addr  = addr;
        ar_valid = 1'b1;
        while (!ar_ready) @(negedge aclk);
        @(negedge aclk);
        ar_valid = 1'b0;
        while (!r_valid) @(negedge aclk);
        data = r_data;
        assert (r_resp == 2'b00) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: r_resp %b on read of %h", $time, r_resp, addr);
        end
        @(negedge aclk);
    endtask

    task automatic check_reg(input logic [4:0] addr, input int expected);
        logic [31:0] rd;
        axil_read(addr, rd);
        assert (rd == 32'(expected)) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: reg %h read %0d expected %0d", $time, addr, rd, expected);
        end
    endtask

    task automatic run_frame(input int f);
        logic [31:0] rd;
        beat_t       b;
        axil_write(ADDR_KW2, f_kw2[f]);
        axil_write(ADDR_SW, f_sw[f]);
        axil_write(ADDR_COLS, f_cols[f]);
        axil_write(ADDR_CINS, f_cins[f]);
        check_reg(ADDR_KW2, f_kw2[f]);
        check_reg(ADDR_SW, f_sw[f]);
        check_reg(ADDR_COLS, f_cols[f]);
        check_reg(ADDR_CINS, f_cins[f]);
        for (int c = -1; c < f_cols[f]; c++) begin
            for (int i = 0; i < ((c < 0) ? 1 : f_cins[f]); i++) begin
                b       = expect_beat(f_kw2[f], f_sw[f], f_cols[f], c);
                b.frame = f;
                exp_q.push_back(b);
            end
        end
        axil_write(ADDR_CTRL, 32'd1);
        axil_read(ADDR_STATUS, rd);
        assert (rd[1:0] == 2'b01) else begin  // busy, old done cleared
            mismatch_cnt++;
            $display("MISMATCH at %0t: status %b after start, expected 01", $time, rd[1:0]);
        end
        do begin
            axil_read(ADDR_STATUS, rd);
        end while (!rd[1]);
        assert (rd[1:0] == 2'b10) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: status %b at end, expected 10", $time, rd[1:0]);
        end
        while (exp_q.size() != 0) @(negedge aclk);  // last beat may still be held
    endtask

    // output side, a beat leaves when beat_valid and out_ready meet at a rising edge
    initial begin
        beat_t                       e;
        logic [MEMBERS*BITS_CLR-1:0] got_clr;
        out_ready = 1'b0;
        forever begin
            @(negedge aclk);
            rdy_rng   = xorshift32(rdy_rng);
            out_ready = (rdy_rng % 100) >= 30;  // ready for the coming rising edge
            if (rst_n && beat_valid && out_ready) begin
                assert (exp_q.size() > 0) else begin
                    other_cnt++;
                    $display("extra beat at %0t with no frame beat left to match", $time);
                end
                if (exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    for (int m = 0; m < MEMBERS; m++) begin
                        got_clr[m*BITS_CLR +: BITS_CLR] = clr[m];
                    end
                    assert (keep_mask == e.keep) else begin
                        mismatch_cnt++;
                        $display("MISMATCH at %0t: frame %0d col %0d keep_mask %h expected %h",
                                 $time, e.frame, e.col, keep_mask, e.keep);
                    end
                    assert (valid_mask == e.valid) else begin
                        mismatch_cnt++;
                        $display("MISMATCH at %0t: frame %0d col %0d valid_mask %b expected %b",
                                 $time, e.frame, e.col, valid_mask, e.valid);
                    end
                    assert (got_clr == e.clr) else begin
                        mismatch_cnt++;
                        $display("MISMATCH at %0t: frame %0d col %0d clr %h expected %h",
                                 $time, e.frame, e.col, got_clr, e.clr);
                    end
                    beats_seen++;
                end
            end
        end
    end

    initial begin
        logic any_zero;
        aw_addr  = '0;
        aw_valid = 1'b0;
        w_data   = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b1;
        ar_addr  = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b1;
        rst_n    = 1'b0;
        any_zero = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            cfg_rng  = xorshift32(cfg_rng);
            f_kw2[f] = cfg_rng % 4;
            if (f > 0 && f_kw2[f] == f_kw2[f-1]) begin
                f_kw2[f] = (f_kw2[f] + 1) % 4;  // kernel changes every frame
            end
            cfg_rng   = xorshift32(cfg_rng);
            f_sw[f]   = cfg_rng % 4;
            cfg_rng   = xorshift32(cfg_rng);
            f_cols[f] = 4 + cfg_rng % 9;
            cfg_rng   = xorshift32(cfg_rng);
            f_cins[f] = 1 + cfg_rng % 4;
            any_zero  = any_zero || (f_kw2[f] == 0);
        end
        if (!any_zero) begin
            f_kw2[3] = 0;  // neighbours are nonzero here
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            total_beats += frame_beats(f_cols[f], f_cins[f]);
        end
        repeat (2) @(negedge aclk);
        rst_n = 1'b1;
        @(negedge aclk);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        repeat (10) @(negedge aclk);  // room for stray beats
        assert (exp_q.size() == 0 && beats_seen == total_beats) else begin
            other_cnt++;
            $display("beat count wrong, %0d beats seen and %0d expected", beats_seen, total_beats);
        end
        $display("done: %0d mismatches, %0d other errors, %0d beats checked",
                 mismatch_cnt, other_cnt, beats_seen);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // about four cycles per beat under throttling, plus AXI traffic
    initial begin
        wait (total_beats > 0);
        #(20 * (total_beats * 4 + 500));
        other_cnt++;
        $display("timeout, the frames did not finish in time");
        $display("done: %0d mismatches, %0d other errors, %0d beats checked",
                 mismatch_cnt, other_cnt, beats_seen);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verif
rtl/conv_pad_pkg.sv
rtl/axil_conv_cfg.sv
rtl/conv_frame_fsm.sv
rtl/col_scan_counter.sv
rtl/pad_filter.sv
rtl/conv_pad_top.sv
verif/tb_conv_pad.sv

// ==== Bender.yml ====
package:
  name: conv_pad

sources:
  # package first, then leaf modules, then the top level
  - rtl/conv_pad_pkg.sv
  - rtl/axil_conv_cfg.sv
  - rtl/conv_frame_fsm.sv
  - rtl/col_scan_counter.sv
  - rtl/pad_filter.sv
  - rtl/conv_pad_top.sv

  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_conv_pad.sv
